/* all.f */
+incdir+.
vis_pkg.sv
vis_ctrl.sv
vis_correlator.sv
vis_prefetch.sv
vis_sram.sv
vis_top.sv
tb_clkgen.sv
vis_chk.sv
vis_tb.sv

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk_o,
   output logic rst_o
);

   initial clk_o = 1'b0;
   always #2 clk_o = ~clk_o;   // 4 ns period

   // reset high over the first four rising edges, released on a falling edge
   initial begin
      rst_o = 1'b1;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

/* vis_chk.sv */
`timescale 1ns/1ps

module vis_chk (
   input logic clk_i,
   input logic rst_i,
   // host bus
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i,
   // correlator bus
   input logic c_cyc_i,
   input logic c_stb_i,
   input logic c_ack_i
);

   // ------------------------------------------------------------------------
   // host handshake
   // ------------------------------------------------------------------------

   a_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
      else $error("host ack_o high for two consecutive cycles");

   a_ack_req: assert property (@(posedge clk_i) disable iff (rst_i)
                               ack_i |-> $past(cyc_i && stb_i))
      else $error("host ack_o without a request");

   // ------------------------------------------------------------------------
   // correlator handshake
   // ------------------------------------------------------------------------

   a_cack_req: assert property (@(posedge clk_i) disable iff (rst_i)
                                c_ack_i |-> $past(c_cyc_i && c_stb_i))
      else $error("correlator c_ack without a request");

   a_cack_pulse: assert property (@(posedge clk_i) disable iff (rst_i) c_ack_i |=> !c_ack_i)
      else $error("correlator c_ack high for two consecutive cycles");

endmodule

/* vis_correlator.sv */
`timescale 1ns/1ps
`include "vis_settings.svh"

module vis_correlator (
   input  logic               clk_i,
   input  logic               rst_i,
   input  vis_pkg::sample_t   sample_i,
   input  logic               sample_valid_i,
   input  logic               swap_i,
   // read-only slave port onto the frozen bank
   input  logic               c_cyc_i,
   input  logic               c_stb_i,
   input  vis_pkg::pair_adr_t c_adr_i,
   output vis_pkg::vis_t      c_dat_o,
   output logic               c_ack_o
);
   import vis_pkg::*;

   localparam int NPAIR = `VIS_NPAIR;
   localparam int NANT  = `VIS_NANT;

   logic [NPAIR-1:0] agree;            // per pair, the two bits match
   vis_t             cnt [2][NPAIR];   // two banks of counters
   logic             act;              // index of the counting bank
   logic             rd;               // fresh request on the slave port

   // ------------------------------------------------------------------------
   // pair agreement, pair p = (a,b) in row-major upper-triangle order
   // ------------------------------------------------------------------------

   for (genvar a = 0; a < NANT - 1; a++) begin : g_row
      for (genvar b = a + 1; b < NANT; b++) begin : g_col
         localparam int P = a * (2 * NANT - a - 1) / 2 + (b - a - 1);
         assign agree[P] = ~(sample_i[a] ^ sample_i[b]);   // xnor
      end
   end

   // ------------------------------------------------------------------------
   // counters
   // ------------------------------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         act <= 1'b0;
         for (int p = 0; p < NPAIR; p++) begin
            cnt[0][p] <= '0;
            cnt[1][p] <= '0;
         end
      end else if (swap_i) begin
         act <= !act;
         // new active bank starts at zero, or one if this sample agrees
         for (int p = 0; p < NPAIR; p++)
            cnt[!act][p] <= vis_t'(sample_valid_i & agree[p]);
      end else if (sample_valid_i) begin
         for (int p = 0; p < NPAIR; p++) begin
            if (agree[p])
               cnt[act][p] <= cnt[act][p] + 1'b1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // slave port, answers one cycle after the request
   // ------------------------------------------------------------------------

   assign rd = c_cyc_i & c_stb_i & ~c_ack_o;

   always_ff @(posedge clk_i) begin
      if (rst_i)
         c_ack_o <= 1'b0;
      else
         c_ack_o <= rd;
   end

   always_ff @(posedge clk_i) begin
      if (rd)
         c_dat_o <= (c_adr_i < NPAIR) ? cnt[!act][c_adr_i] : '0;   // frozen bank
   end

endmodule

/* vis_ctrl.sv */
`timescale 1ns/1ps
`include "vis_settings.svh"

module vis_ctrl (
   input  logic               clk_i,
   input  logic               rst_i,
   // host slave bus
   input  logic               cyc_i,
   input  logic               stb_i,
   input  logic               we_i,
   input  vis_pkg::byte_adr_t adr_i,
   input  logic [7:0]         byt_i,
   output logic               ack_o,
   output logic [7:0]         byt_o,
   // window control
   input  logic               sample_valid_i,
   output logic               swap_o,
   input  logic               pf_busy_i,
   input  logic               pf_done_i,
   // buffer sram read port
   output vis_pkg::byte_adr_t r_adr_o,
   input  logic [7:0]         r_byt_i,
   output logic               available_o
);
   import vis_pkg::*;

   localparam int BUF_BYTES = `VIS_NPAIR * 4;   // 112 bytes of counts

   logic [4:0] win_log;     // window-log register
   logic [4:0] log_new;     // clamped write value
   win_cnt_t   win_cnt;     // valid samples seen in this window
   win_cnt_t   win_last;    // 2**win_log - 1
   logic       win_end;     // this sample completes the window
   logic       overrun;
   logic       req;         // fresh host request
   logic       wr_status;
   logic       wr_log;
   logic       sel_buf;     // ack cycle returns sram byte
   logic [7:0] reg_byt;     // ack cycle register value
   logic [7:0] status;

   // ------------------------------------------------------------------------
   // host decode
   // ------------------------------------------------------------------------

   assign req       = cyc_i & stb_i & ~ack_o;   // ack gaps the second edge
   assign wr_status = req & we_i & (adr_i == `VIS_REG_STATUS);
   assign wr_log    = req & we_i & (adr_i == `VIS_REG_LOG);
   assign log_new   = (byt_i[4:0] > 5'(`VIS_MAX_LOG)) ? 5'(`VIS_MAX_LOG) : byt_i[4:0];
   assign status    = {available_o, overrun, 6'b0};

   assign r_adr_o = adr_i;   // sram registers it on the request edge

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o   <= 1'b0;
         sel_buf <= 1'b0;
      end else begin
         ack_o <= req;                                // one cycle only
         if (req)
            sel_buf <= (adr_i < BUF_BYTES) & ~we_i;
      end
   end

   // register read value, sampled with the request
   always_ff @(posedge clk_i) begin
      if (req) begin
         case (adr_i)
            `VIS_REG_STATUS: reg_byt <= status;
            `VIS_REG_LOG:    reg_byt <= {3'b0, win_log};
            default:         reg_byt <= 8'h00;        // unmapped reads 0
         endcase
      end
   end

   assign byt_o = sel_buf ? r_byt_i : reg_byt;

   // ------------------------------------------------------------------------
   // window counter and swap
   // ------------------------------------------------------------------------

   assign win_last = (win_cnt_t'(1) << win_log) - 1'b1;
   assign win_end  = sample_valid_i & (win_cnt == win_last);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         win_log <= 5'd0;
         win_cnt <= '0;
         swap_o  <= 1'b0;
      end else begin
         swap_o <= win_end;              // one cycle after the last sample
         if (wr_log) begin
            win_log <= log_new;
            win_cnt <= '0;               // new length starts a fresh count
         end else if (win_end) begin
            win_cnt <= '0;
         end else if (sample_valid_i) begin
            win_cnt <= win_cnt + 1'b1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // status flags
   // ------------------------------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         available_o <= 1'b0;
         overrun     <= 1'b0;
      end else begin
         if (swap_o)
            available_o <= 1'b0;         // frozen bank is being replaced
         else if (pf_done_i)
            available_o <= 1'b1;
         if (swap_o && pf_busy_i)
            overrun <= 1'b1;             // previous copy never finished
         else if (wr_status)
            overrun <= 1'b0;             // any write to E0 clears
      end
   end

endmodule

/* vis_pkg.sv */
`include "vis_settings.svh"

package vis_pkg;

   // ------------------------------------------------------------------------
   // vectors that carry a meaning
   // ------------------------------------------------------------------------

   typedef logic [`VIS_NANT-1:0]  sample_t;    // one bit per antenna
   typedef logic [`VIS_WIDTH-1:0] vis_t;       // one agreement count
   typedef logic [4:0]            pair_adr_t;  // pair index on correlator bus
   typedef logic [7:0]            byte_adr_t;  // host byte address

   // must hold 2**VIS_MAX_LOG
   typedef logic [20:0]           win_cnt_t;

   // ------------------------------------------------------------------------
   // prefetch engine states
   // ------------------------------------------------------------------------

   typedef enum logic [1:0] {
      PF_IDLE,    // nothing to copy
      PF_REQ,     // request issued on correlator bus
      PF_WAIT,    // waiting for c_ack
      PF_WRITE    // word goes to the buffer sram
   } pf_state_t;

endpackage

/* vis_prefetch.sv */
`timescale 1ns/1ps
`include "vis_settings.svh"

module vis_prefetch (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               swap_i,
   // master on the correlator bus
   output logic               c_cyc_o,
   output logic               c_stb_o,
   output vis_pkg::pair_adr_t c_adr_o,
   input  vis_pkg::vis_t      c_dat_i,
   input  logic               c_ack_i,
   // fill port into the buffer sram
   output logic               f_we_o,
   output vis_pkg::pair_adr_t f_adr_o,
   output vis_pkg::vis_t      f_dat_o,
   // progress
   output logic               busy_o,
   output logic               done_o
);
   import vis_pkg::*;

   localparam pair_adr_t LAST = pair_adr_t'(`VIS_NPAIR - 1);

   pf_state_t state;
   pair_adr_t pair;    // pair being copied
   logic      last;    // pair is the final one

   assign last = (pair == LAST);

   // ------------------------------------------------------------------------
   // sequencer, three cycles per pair when the slave answers at once
   // ------------------------------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state <= PF_IDLE;
         pair  <= '0;
      end else if (swap_i) begin
         state <= PF_REQ;                // restart on any swap
         pair  <= '0;
      end else begin
         case (state)
            PF_IDLE: begin
               state <= PF_IDLE;
            end
            PF_REQ: begin
               state <= PF_WAIT;          // any ack seen here is stale
            end
            PF_WAIT: begin
               if (c_ack_i)
                  state <= PF_WRITE;
            end
            PF_WRITE: begin
               if (last) begin
                  state <= PF_IDLE;
               end else begin
                  pair  <= pair + 1'b1;
                  state <= PF_REQ;
               end
            end
            default: state <= PF_IDLE;
         endcase
      end
   end

   // capture the count as it is acked
   always_ff @(posedge clk_i) begin
      if (state == PF_WAIT && c_ack_i)
         f_dat_o <= c_dat_i;
   end

   // ------------------------------------------------------------------------
   // outputs
   // ------------------------------------------------------------------------

   assign c_cyc_o = (state == PF_REQ) || (state == PF_WAIT);   // held until ack
   assign c_stb_o = c_cyc_o;
   assign c_adr_o = pair;

   assign f_we_o  = (state == PF_WRITE);
   assign f_adr_o = pair;

   assign busy_o  = (state != PF_IDLE);
   assign done_o  = (state == PF_WRITE) && last;   // final word lands this edge

endmodule

/* vis_settings.svh */
`ifndef VIS_SETTINGS_SVH
`define VIS_SETTINGS_SVH

// ---------------------------------------------------------------------------
// array geometry
// ---------------------------------------------------------------------------

// antennas, one sample bit each per valid cycle
`define VIS_NANT 8

// unique antenna pairs, ordered (0,1),(0,2)..(0,7),(1,2)..(6,7)
`define VIS_NPAIR 28

// width of one agreement count
`define VIS_WIDTH 32

// ---------------------------------------------------------------------------
// host register map
// ---------------------------------------------------------------------------

`define VIS_REG_STATUS 8'hE0   // bit 7 available, bit 6 overrun
`define VIS_REG_LOG    8'hE1   // log2 of the window length

// window log is clamped to this on write
`define VIS_MAX_LOG 20

`endif

/* vis_sram.sv */
`timescale 1ns/1ps
`include "vis_settings.svh"

module vis_sram (
   input  logic               clk_i,
   // word-wide fill port
   input  logic               f_we_i,
   input  vis_pkg::pair_adr_t f_adr_i,
   input  vis_pkg::vis_t      f_dat_i,
   // byte-wide read port
   input  vis_pkg::byte_adr_t r_adr_i,
   output logic [7:0]         r_byt_o
);
   import vis_pkg::*;

   localparam int NPAIR     = `VIS_NPAIR;
   localparam int BUF_BYTES = NPAIR * 4;

   vis_t mem [NPAIR];   // one word per pair
   vis_t word;          // addressed word, read side
   logic in_range;      // byte address falls in the buffer

   // ------------------------------------------------------------------------
   // write side
   // ------------------------------------------------------------------------

   always_ff @(posedge clk_i) begin
      if (f_we_i)
         mem[f_adr_i] <= f_dat_i;
   end

   // ------------------------------------------------------------------------
   // read side
   // ------------------------------------------------------------------------

   assign in_range = (r_adr_i < BUF_BYTES);
   assign word     = in_range ? mem[r_adr_i[6:2]] : '0;

   // little-endian, byte k of a word sits at address 4p+k
   always_ff @(posedge clk_i) begin
      case (r_adr_i[1:0])
         2'd0:    r_byt_o <= word[7:0];
         2'd1:    r_byt_o <= word[15:8];
         2'd2:    r_byt_o <= word[23:16];
         default: r_byt_o <= word[31:24];
      endcase
   end

endmodule

/* vis_tb.sv */
`timescale 1ns/1ps
`include "vis_settings.svh"

module vis_tb;
   import vis_pkg::*;

   localparam int N_WIN   = 2;                              // long windows in the run
   localparam int WIN_LEN = 64;                             // log 6
   localparam int WD_NS   = 64 * (N_WIN * WIN_LEN + 200);   // watchdog limit

   logic        clk;
   logic        rst;
   sample_t     sample;
   logic        sample_valid;
   logic        cyc;
   logic        stb;
   logic        we;
   byte_adr_t   adr;
   logic [7:0]  wbyt;
   logic        ack;
   logic [7:0]  rbyt;
   logic        available;

   integer      seed = 32'h8c222d98;
   int          errors = 0;
   sample_t     win_q [$];        // valid samples of the current window
   string       name_q [$];       // pending checks for the compare process
   logic [31:0] got_q [$];
   logic [31:0] exp_q [$];
   string       c_name;
   logic [31:0] c_got;
   logic [31:0] c_exp;

   tb_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

   vis_top u_vis_top (
      .clk_i          (clk),
      .rst_i          (rst),
      .sample_i       (sample),
      .sample_valid_i (sample_valid),
      .cyc_i          (cyc),
      .stb_i          (stb),
      .we_i           (we),
      .adr_i          (adr),
      .byt_i          (wbyt),
      .ack_o          (ack),
      .byt_o          (rbyt),
      .available_o    (available)
   );

   bind vis_top vis_chk u_chk (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .cyc_i   (cyc_i),
      .stb_i   (stb_i),
      .ack_i   (ack_o),
      .c_cyc_i (c_cyc),
      .c_stb_i (c_stb),
      .c_ack_i (c_ack)
   );

   // ------------------------------------------------------------------------
   // reference model, agreements of pair p over the stored window
   // ------------------------------------------------------------------------

   function automatic logic [31:0] ref_count(input int p);
      int          idx;
      logic [31:0] n;
      idx = 0;
      n   = '0;
      for (int a = 0; a < `VIS_NANT - 1; a++) begin
         for (int b = a + 1; b < `VIS_NANT; b++) begin
            if (idx == p) begin
               foreach (win_q[i])
                  if (win_q[i][a] == win_q[i][b]) n++;   // bits agree
            end
            idx++;
         end
      end
      return n;
   endfunction

   task automatic push_check(input string name, input logic [31:0] got, input logic [31:0] exp);
      name_q.push_back(name);
      got_q.push_back(got);
      exp_q.push_back(exp);
   endtask

   // compare process, drains whatever the stimulus queued
   always @(posedge clk) begin
      while (got_q.size() > 0) begin
         c_name = name_q.pop_front();
         c_got  = got_q.pop_front();
         c_exp  = exp_q.pop_front();
         if (c_got !== c_exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h",
                     $time, c_name, c_got, c_exp);
         end
      end
   end

   // ------------------------------------------------------------------------
   // host bus tasks, inputs change on the falling edge
   // ------------------------------------------------------------------------

   task automatic host_xfer(input logic wr, input byte_adr_t a, input logic [7:0] d,
                            output logic [7:0] q);
      int n;
      @(negedge clk);
      cyc  = 1'b1;
      stb  = 1'b1;
      we   = wr;
      adr  = a;
      wbyt = d;
      n    = 0;
      do begin
         @(negedge clk);   // ack and data stable here
         n++;
      end while (!ack && n < 16);
      if (!ack) begin
         errors++;
         $display("ERROR at %0t ns: no ack for access to address %h", $time, a);
      end else begin
         push_check("ack_o latency", n, 1);   // ack on the first cycle after the request
      end
      q   = rbyt;
      cyc = 1'b0;          // drop request for at least a cycle
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic host_read(input byte_adr_t a, output logic [7:0] q);
      host_xfer(1'b0, a, 8'h00, q);
   endtask

   task automatic host_write(input byte_adr_t a, input logic [7:0] d);
      logic [7:0] dummy;
      host_xfer(1'b1, a, d, dummy);
   endtask

   // ------------------------------------------------------------------------
   // stimulus helpers
   // ------------------------------------------------------------------------

   task automatic feed_window(input int n, input bit gaps);
      int sent;
      win_q.delete();
      sent = 0;
      while (sent < n) begin
         @(negedge clk);
         if (gaps && (($random(seed) & 3) == 0)) begin
            sample_valid = 1'b0;                 // idle cycle
         end else begin
            sample       = sample_t'($random(seed));
            sample_valid = 1'b1;
            win_q.push_back(sample);
            sent++;
         end
      end
      @(negedge clk);
      sample_valid = 1'b0;
   endtask

   task automatic wait_avail(input logic level, input int limit, input string what);
      int n;
      n = 0;
      while (available !== level && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (available !== level) begin
         errors++;
         $display("ERROR at %0t ns: available_o did not %s", $time, what);
      end
   endtask

   // all 112 bytes, reassembled little-endian per pair
   task automatic read_buffer();
      logic [7:0]  b;
      logic [31:0] word;
      for (int p = 0; p < `VIS_NPAIR; p++) begin
         for (int k = 0; k < 4; k++) begin
            host_read(byte_adr_t'(4 * p + k), b);
            word[8*k +: 8] = b;
         end
         push_check($sformatf("vis[%0d]", p), word, ref_count(p));
      end
   endtask

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------

   initial begin : stimulus
      logic [7:0] b;
      sample       = '0;
      sample_valid = 1'b0;
      cyc          = 1'b0;
      stb          = 1'b0;
      we           = 1'b0;
      adr          = '0;
      wbyt         = '0;
      @(negedge rst);

      push_check("available_o", available, 0);   // reset state
      host_read(`VIS_REG_STATUS, b);
      push_check("status", b, 8'h00);
      host_read(`VIS_REG_LOG, b);
      push_check("win_log", b, 8'h00);

      host_write(`VIS_REG_LOG, 8'd5);
      host_read(`VIS_REG_LOG, b);
      push_check("win_log", b, 8'd5);
      host_write(`VIS_REG_LOG, 8'd31);            // clamps to max
      host_read(`VIS_REG_LOG, b);
      push_check("win_log", b, `VIS_MAX_LOG);

      host_write(`VIS_REG_LOG, 8'd6);             // first window, gaps between samples
      feed_window(WIN_LEN, 1'b1);
      wait_avail(1'b1, 200, "rise after the first window");
      read_buffer();

      push_check("available_o", available, 1);   // second window, fresh counts
      feed_window(WIN_LEN, 1'b1);
      wait_avail(1'b0, 4, "clear at the swap");
      wait_avail(1'b1, 200, "rise after the second window");
      read_buffer();

      host_write(`VIS_REG_LOG, 8'd2);             // swaps every 4 cycles hit the copy
      feed_window(16, 1'b0);
      wait_avail(1'b1, 200, "rise after the short windows");
      host_read(`VIS_REG_STATUS, b);
      push_check("status", b, 8'hC0);
      host_write(`VIS_REG_STATUS, 8'h00);        // clears overrun
      host_read(`VIS_REG_STATUS, b);
      push_check("status", b, 8'h80);

      host_read(8'hF0, b);                        // unmapped
      push_check("unmapped", b, 8'h00);

      repeat (2) @(negedge clk);                  // let the compare queue drain
      $display("checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WD_NS);
      $display("watchdog expired after %0d ns, the run did not finish", WD_NS);
      $display("Test failed");
      $finish;
   end

endmodule

/* vis_top.sv */
`timescale 1ns/1ps

module vis_top (
   input  logic               clk_i,
   input  logic               rst_i,
   input  vis_pkg::sample_t   sample_i,
   input  logic               sample_valid_i,
   // host slave bus
   input  logic               cyc_i,
   input  logic               stb_i,
   input  logic               we_i,
   input  vis_pkg::byte_adr_t adr_i,
   input  logic [7:0]         byt_i,
   output logic               ack_o,
   output logic [7:0]         byt_o,
   output logic               available_o
);
   import vis_pkg::*;

   logic      swap;       // bank exchange pulse
   logic      pf_busy;
   logic      pf_done;
   byte_adr_t r_adr;      // host read into the buffer
   logic [7:0] r_byt;

   // correlator bus
   logic      c_cyc;
   logic      c_stb;
   pair_adr_t c_adr;
   vis_t      c_dat;
   logic      c_ack;

   // buffer fill port
   logic      f_we;
   pair_adr_t f_adr;
   vis_t      f_dat;

   // ------------------------------------------------------------------------
   // control and host registers
   // ------------------------------------------------------------------------

   vis_ctrl u_ctrl (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .cyc_i          (cyc_i),
      .stb_i          (stb_i),
      .we_i           (we_i),
      .adr_i          (adr_i),
      .byt_i          (byt_i),
      .ack_o          (ack_o),
      .byt_o          (byt_o),
      .sample_valid_i (sample_valid_i),
      .swap_o         (swap),
      .pf_busy_i      (pf_busy),
      .pf_done_i      (pf_done),
      .r_adr_o        (r_adr),
      .r_byt_i        (r_byt),
      .available_o    (available_o)
   );

   // ------------------------------------------------------------------------
   // datapath
   // ------------------------------------------------------------------------

   vis_correlator u_corr (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .sample_i       (sample_i),
      .sample_valid_i (sample_valid_i),
      .swap_i         (swap),
      .c_cyc_i        (c_cyc),
      .c_stb_i        (c_stb),
      .c_adr_i        (c_adr),
      .c_dat_o        (c_dat),
      .c_ack_o        (c_ack)
   );

   vis_prefetch u_prefetch (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .swap_i  (swap),
      .c_cyc_o (c_cyc),
      .c_stb_o (c_stb),
      .c_adr_o (c_adr),
      .c_dat_i (c_dat),
      .c_ack_i (c_ack),
      .f_we_o  (f_we),
      .f_adr_o (f_adr),
      .f_dat_o (f_dat),
      .busy_o  (pf_busy),
      .done_o  (pf_done)
   );

   vis_sram u_sram (
      .clk_i   (clk_i),
      .f_we_i  (f_we),
      .f_adr_i (f_adr),
      .f_dat_i (f_dat),
      .r_adr_i (r_adr),
      .r_byt_o (r_byt)
   );

endmodule
